// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= idac_tb
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/idac_sva.sv ====
`timescale 1ns/100ps

module idac_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       out_en,
    input logic [idac_pkg::SUM_W-1:0] iout,
    input logic [idac_pkg::SUM_W-1:0] ioutb,
    input logic [idac_pkg::SUM_W-1:0] ical,
    input idac_pkg::power_state_t     state
);
    import idac_pkg::*;

    int fail_count = 0;

    a_reset_off: assert property (@(posedge clk) !rst_n |-> !out_en)
        else begin
            $error("out_en high during reset");
            fail_count++;
        end

    // out_en lags the fsm by one register stage
    a_on_only: assert property (@(posedge clk) disable iff (!rst_n)
        out_en |-> $past(state) == PWR_ON)
        else begin
            $error("out_en high while the fsm was not in PWR_ON");
            fail_count++;
        end

    a_zero_off: assert property (@(posedge clk)
        !out_en |-> (iout == '0 && ioutb == '0 && ical == '0))
        else begin
            $error("nonzero current with out_en low");
            fail_count++;
        end

    a_no_skip: assert property (@(posedge clk) disable iff (!rst_n)
        state == PWR_OFF |=> state != PWR_ON)
        else begin
            $error("fsm went from PWR_OFF straight to PWR_ON");
            fail_count++;
        end

endmodule

// ==== bench/idac_tb.sv ====
`timescale 1ns/100ps

module idac_tb;
    import idac_pkg::*;

    localparam int SETTLE_CYCLES = 16;
    localparam int WAIT_LIMIT    = 200;  // edges before a wait gives up
    localparam int N_RANDOM      = 300;

    typedef struct packed {
        int io;
        int iob;
        int ic;
        bit ce;
    } exp_t;

    typedef struct packed {
        logic [N_BIN-1:0]   din;
        logic [N_BIN-1:0]   dinb;
        logic [N_THERM-1:0] dt;
        logic [N_THERM-1:0] dtb;
        logic [CAL_W-1:0]   cal;
        exp_t               exp;
    } vec_t;

    logic               clk;
    logic               rst_n;
    logic               pdb;
    logic [N_BIN-1:0]   datain;
    logic [N_BIN-1:0]   datainb;
    logic [N_THERM-1:0] datatherm;
    logic [N_THERM-1:0] datathermb;
    logic [CAL_W-1:0]   dataical;
    logic [SUM_W-1:0]   iout;
    logic [SUM_W-1:0]   ioutb;
    logic [SUM_W-1:0]   ical;
    logic               out_en;
    logic               ical_en;

    int   checks;
    int   errors;
    int   mark_checks;
    int   mark_errors;
    vec_t vec_table[$];
    exp_t exp_q[$];

    idac_top #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pdb        (pdb),
        .datain     (datain),
        .datainb    (datainb),
        .datatherm  (datatherm),
        .datathermb (datathermb),
        .dataical   (dataical),
        .iout       (iout),
        .ioutb      (ioutb),
        .ical       (ical),
        .out_en     (out_en),
        .ical_en    (ical_en)
    );

    bind idac_top idac_sva u_sva (
        .clk    (clk),
        .rst_n  (rst_n),
        .out_en (out_en),
        .iout   (iout),
        .ioutb  (ioutb),
        .ical   (ical),
        .state  (u_power_fsm.state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected currents built cell by cell from the steering rules
    function automatic exp_t model_outputs(input logic [N_BIN-1:0] din,
                                           input logic [N_BIN-1:0] dinb,
                                           input logic [N_THERM-1:0] dt,
                                           input logic [N_THERM-1:0] dtb,
                                           input logic [CAL_W-1:0] cal);
        exp_t e;
        int   w;
        int   code;
        int   sel_cell;
        logic d;
        logic db;
        e = '0;
        code = int'(cal);
        sel_cell = -1;
        if (code >= 1 && code < CAL_FIRST_THERM) begin
            sel_cell = code - 1;  // binary cells
        end else if (code >= CAL_FIRST_THERM && code <= CAL_LAST) begin
            sel_cell = N_BIN + code - CAL_FIRST_THERM;
        end
        for (int k = 0; k < N_BIN + N_THERM; k++) begin
            if (k < N_BIN) begin
                w = 1 << k;
                d = din[k];
                db = dinb[k];
            end else begin
                w = THERM_WEIGHT;
                d = dt[k-N_BIN];
                db = dtb[k-N_BIN];
            end
            if (k == sel_cell) begin
                e.ic = (code == 1) ? 1 : w;  // code 1 measures the redundant lsb
                e.ce = 1'b1;
            end else if (d && !db) begin
                e.io = e.io + w;
            end else if (!d && db) begin
                e.iob = e.iob + w;
            end
        end
        return e;
    endfunction

    function automatic vec_t make_vec(input logic [N_BIN-1:0] din, input logic [N_BIN-1:0] dinb,
                                      input logic [N_THERM-1:0] dt,
                                      input logic [N_THERM-1:0] dtb,
                                      input logic [CAL_W-1:0] cal,
                                      input int io, input int iob, input int ic, input bit ce);
        vec_t v;
        v.din = din;
        v.dinb = dinb;
        v.dt = dt;
        v.dtb = dtb;
        v.cal = cal;
        v.exp = '{io: io, iob: iob, ic: ic, ce: ce};
        return v;
    endfunction

    task automatic apply_vec(input vec_t v);
        datain = v.din;
        datainb = v.dinb;
        datatherm = v.dt;
        datathermb = v.dtb;
        dataical = v.cal;
    endtask

    task automatic check_outputs(input exp_t e, input string what);
        checks++;
        if (!out_en || int'(iout) != e.io || int'(ioutb) != e.iob || int'(ical) != e.ic
                || ical_en != e.ce) begin
            errors++;
            $display("Fail at %0d ns: %s got out_en=%0b iout=%0d ioutb=%0d ical=%0d ical_en=%0b,",
                     $time, what, out_en, iout, ioutb, ical, ical_en);
            $display("    expected out_en=1 iout=%0d ioutb=%0d ical=%0d ical_en=%0b",
                     e.io, e.iob, e.ic, e.ce);
        end
    endtask

    // pdb was raised just before the calling negedge
    task automatic check_power_up();
        int edges;
        edges = 0;
        while (!out_en && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;  // first count is edge P itself
            if (!out_en && (iout != '0 || ioutb != '0 || ical != '0 || ical_en)) begin
                errors++;
                $display("Fail at %0d ns: outputs not zero while settling", $time);
            end
        end
        checks++;
        if (!out_en) begin
            errors++;
            $display("timeout: out_en never rose within %0d cycles of power-up", WAIT_LIMIT);
        end else if (edges - 1 != SETTLE_CYCLES + 2) begin
            errors++;
            $display("Fail at %0d ns: out_en rose %0d edges after P, expected %0d",
                     $time, edges - 1, SETTLE_CYCLES + 2);
        end
    endtask

    task automatic start_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    initial begin
        vec_t v;
        exp_t e;
        int   edges;
        void'($urandom(74332));
        rst_n = 1'b0;
        pdb = 1'b0;
        checks = 0;
        errors = 0;
        apply_vec(make_vec('1, '0, '1, '0, '0, 0, 0, 0, 1'b0));
        //           din    dinb   dt        dtb       cal    iout ioutb ical en
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd0, 1151, 0, 0, 1'b0));
        vec_table.push_back(make_vec(6'h00, 6'h3f, 17'h00000, 17'h1ffff, 5'd0, 0, 1151, 0, 1'b0));
        vec_table.push_back(make_vec(6'h2a, 6'h15, 17'h000ff, 17'h1ff00, 5'd0, 554, 597, 0, 1'b0));
        vec_table.push_back(make_vec(6'h05, 6'h3a, 17'h00001, 17'h1fffe, 5'd0, 69, 1082, 0, 1'b0));
        vec_table.push_back(make_vec(6'h3f, 6'h0f, 17'h0000f, 17'h00003, 5'd0, 176, 0, 0, 1'b0));
        vec_table.push_back(make_vec(6'h00, 6'h00, 17'h00000, 17'h00000, 5'd0, 0, 0, 0, 1'b0));
        vec_table.push_back(make_vec(6'h3f, 6'h3f, 17'h1ffff, 17'h1ffff, 5'd0, 0, 0, 0, 1'b0));
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd1, 1150, 0, 1, 1'b1));
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd6, 1119, 0, 32, 1'b1));
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd7, 1087, 0, 64, 1'b1));
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd23, 1087, 0, 64, 1'b1));
        vec_table.push_back(make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd24, 1151, 0, 0, 1'b0));
        vec_table.push_back(make_vec(6'h00, 6'h3f, 17'h00000, 17'h1ffff, 5'd3, 0, 1147, 4, 1'b1));

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        start_test();
        @(negedge clk);
        pdb = 1'b1;
        check_power_up();
        end_test("power_up");

        start_test();
        foreach (vec_table[i]) begin
            apply_vec(vec_table[i]);
            repeat (3) @(negedge clk);
            check_outputs(vec_table[i].exp, $sformatf("table entry %0d", i));
        end
        end_test("table");

        start_test();
        for (int code = 0; code < 32; code++) begin
            @(negedge clk);
            v = make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, CAL_W'(code), 0, 0, 0, 1'b0);
            apply_vec(v);
            repeat (3) @(negedge clk);
            check_outputs(model_outputs(v.din, v.dinb, v.dt, v.dtb, v.cal),
                          $sformatf("dataical %0d", code));
        end
        end_test("calibration");

        start_test();
        for (int i = 0; i < N_RANDOM + 2; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_outputs(exp_q.pop_front(), $sformatf("random vector %0d", i - 2));
            end
            if (i < N_RANDOM) begin
                v.din = N_BIN'($urandom);
                v.dt = N_THERM'($urandom);
                v.dinb = ($urandom_range(3) == 0) ? N_BIN'($urandom) : ~v.din;
                v.dtb = ($urandom_range(3) == 0) ? N_THERM'($urandom) : ~v.dt;
                v.cal = CAL_W'($urandom_range(31));
                apply_vec(v);
                exp_q.push_back(model_outputs(v.din, v.dinb, v.dt, v.dtb, v.cal));
            end
        end
        end_test("random");

        start_test();
        @(negedge clk);
        v = make_vec(6'h3f, 6'h00, 17'h1ffff, 17'h00000, 5'd5, 0, 0, 0, 1'b0);
        apply_vec(v);
        repeat (3) @(negedge clk);
        e = model_outputs(v.din, v.dinb, v.dt, v.dtb, v.cal);
        check_outputs(e, "before power-down");
        pdb = 1'b0;
        edges = 0;
        while (out_en && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        checks++;
        if (out_en) begin
            errors++;
            $display("timeout: out_en stayed high after pdb went low");
        end else if (edges != 2 || ical_en || iout != '0 || ioutb != '0 || ical != '0) begin
            errors++;
            $display("Fail at %0d ns: power-down after %0d edges, ical_en=%0b sums %0d %0d %0d",
                     $time, edges, ical_en, iout, ioutb, ical);
        end
        pdb = 1'b1;
        check_power_up();
        repeat (2) @(negedge clk);
        check_outputs(e, "after second power-up");
        end_test("power_down");

        if (dut.u_sva.fail_count != 0) begin
            errors = errors + dut.u_sva.fail_count;
            $display("%0d concurrent assertions failed", dut.u_sva.fail_count);
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/idac_pkg.sv
hw/idac_power_fsm.sv
hw/idac_settle_timer.sv
hw/idac_cell_decoder.sv
hw/idac_current_sum.sv
hw/idac_top.sv
bench/idac_sva.sv
bench/idac_tb.sv

// ==== hw/idac_cell_decoder.sv ====
`timescale 1ns/100ps

module idac_cell_decoder (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [idac_pkg::N_BIN-1:0]                    datain,
    input  logic [idac_pkg::N_BIN-1:0]                    datainb,
    input  logic [idac_pkg::N_THERM-1:0]                  datatherm,
    input  logic [idac_pkg::N_THERM-1:0]                  datathermb,
    input  logic [idac_pkg::CAL_W-1:0]                    dataical,
    output logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  pos_mask,
    output logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  neg_mask,
    output logic                                          cal_bin_red,
    output logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  cal_therm
);
    import idac_pkg::*;

    localparam int N_CELLS = N_BIN + N_THERM;

    logic [N_CELLS-1:0] data_all;   // binary cells in the low bits
    logic [N_CELLS-1:0] datab_all;
    logic [N_CELLS-1:0] cal_sel;    // cell pulled out of both sums
    logic [N_CELLS-1:0] pos_next;
    logic [N_CELLS-1:0] neg_next;
    logic               red_next;

    assign data_all  = {datatherm, datain};
    assign datab_all = {datathermb, datainb};

    // one-hot cell select from the calibration code
    always_comb begin
        cal_sel = '0;
        if (dataical != '0 && int'(dataical) < CAL_FIRST_THERM) begin
            cal_sel[int'(dataical) - 1] = 1'b1;  // binary cells 0 to 5
        end else if (int'(dataical) >= CAL_FIRST_THERM && int'(dataical) <= CAL_LAST) begin
            cal_sel[N_BIN + int'(dataical) - CAL_FIRST_THERM] = 1'b1;
        end
    end

    // code 1 measures the redundant lsb in place of binary cell 0
    assign red_next = (dataical == CAL_W'(1));

    // a cell steers only when its pair is complementary
    assign pos_next = data_all & ~datab_all & ~cal_sel;
    assign neg_next = ~data_all & datab_all & ~cal_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_mask    <= '0;
            neg_mask    <= '0;
            cal_bin_red <= 1'b0;
            cal_therm   <= '0;
        end else begin
            pos_mask    <= pos_next;
            neg_mask    <= neg_next;
            cal_bin_red <= red_next;
            cal_therm   <= cal_sel & ~{N_CELLS{red_next}};
        end
    end

endmodule

// ==== hw/idac_current_sum.sv ====
`timescale 1ns/100ps

module idac_current_sum (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          active,
    input  logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  pos_mask,
    input  logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  neg_mask,
    input  logic                                          cal_bin_red,
    input  logic [idac_pkg::N_BIN+idac_pkg::N_THERM-1:0]  cal_therm,
    output logic [idac_pkg::SUM_W-1:0]                    iout,
    output logic [idac_pkg::SUM_W-1:0]                    ioutb,
    output logic [idac_pkg::SUM_W-1:0]                    ical,
    output logic                                          out_en,
    output logic                                          ical_en
);
    import idac_pkg::*;

    localparam int N_CELLS = N_BIN + N_THERM;

    logic [SUM_W-1:0] pos_sum;
    logic [SUM_W-1:0] neg_sum;
    logic [SUM_W-1:0] cal_sum;
    logic             cal_any;

    // current of one cell in lsb units
    function automatic logic [SUM_W-1:0] cell_weight(input int idx);
        if (idx < N_BIN) begin
            return SUM_W'(1) << idx;
        end
        return SUM_W'(THERM_WEIGHT);
    endfunction

    always_comb begin
        pos_sum = '0;
        neg_sum = '0;
        cal_sum = {{(SUM_W-1){1'b0}}, cal_bin_red};  // redundant cell weighs 1
        for (int i = 0; i < N_CELLS; i++) begin
            if (pos_mask[i]) begin
                pos_sum = pos_sum + cell_weight(i);
            end
            if (neg_mask[i]) begin
                neg_sum = neg_sum + cell_weight(i);
            end
            if (cal_therm[i]) begin
                cal_sum = cal_sum + cell_weight(i);
            end
        end
    end

    assign cal_any = cal_bin_red || (cal_therm != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iout    <= '0;
            ioutb   <= '0;
            ical    <= '0;
            out_en  <= 1'b0;
            ical_en <= 1'b0;
        end else begin
            iout    <= active ? pos_sum : '0;  // powered down reads zero
            ioutb   <= active ? neg_sum : '0;
            ical    <= active ? cal_sum : '0;
            out_en  <= active;
            ical_en <= active && cal_any;
        end
    end

endmodule

// ==== hw/idac_pkg.sv ====
package idac_pkg;

    // segment structure of the converter
    localparam int N_BIN   = 6;   // binary weighted cells, lsb first
    localparam int N_THERM = 17;  // unary thermometer cells

    // calibration select
    localparam int CAL_W           = 5;   // index of the cell routed to ical
    localparam int CAL_FIRST_THERM = 7;   // first code that picks a thermometer cell
    localparam int CAL_LAST        = 23;  // codes above this select nothing

    // currents in units of one lsb cell
    localparam int THERM_WEIGHT = 64;  // one thermometer cell
    localparam int SUM_W        = 11;  // full scale is 63 + 17*64 = 1151

    // power sequencing
    typedef enum logic [1:0] {
        PWR_OFF,     // powered down, outputs forced to zero
        PWR_SETTLE,  // bias settling after power-up
        PWR_ON       // cells steer the outputs
    } power_state_t;

endpackage

// ==== hw/idac_power_fsm.sv ====
`timescale 1ns/100ps

module idac_power_fsm #(
    parameter int SETTLE_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pdb,          // power-down negate, level
    input  logic settle_done,  // one-cycle pulse from the settle timer
    output logic timer_start,  // starts the settle count
    output logic active        // cells may drive the outputs
);
    import idac_pkg::*;

    power_state_t state;
    power_state_t state_next;

    // the timer samples this on the same edge that leaves PWR_OFF,
    // so the settle count begins on the power-up edge itself
    assign timer_start = (state == PWR_OFF) && pdb;
    assign active      = (state == PWR_ON);

    always_comb begin
        state_next = state;
        if (!pdb) begin
            state_next = PWR_OFF;  // power-down wins in every state
        end else begin
            case (state)
                PWR_OFF:    state_next = PWR_SETTLE;
                PWR_SETTLE: begin
                    if (settle_done) begin
                        state_next = PWR_ON;
                    end
                end
                PWR_ON:     state_next = PWR_ON;
                default:    state_next = PWR_OFF;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PWR_OFF;
        end else begin
            state <= state_next;
        end
    end

    // a zero settle length would leave settle_done stuck low
    initial begin
        if (SETTLE_CYCLES < 1) begin
            $error("SETTLE_CYCLES must be 1 or more");
        end
    end

endmodule

// ==== hw/idac_settle_timer.sv ====
`timescale 1ns/100ps

module idac_settle_timer #(
    parameter int SETTLE_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,  // load, also restarts an aborted count
    output logic settle_done   // high for one cycle when the count expires
);
    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            settle_done <= 1'b0;
        end else if (timer_start) begin
            cnt         <= CNT_W'(SETTLE_CYCLES);
            settle_done <= 1'b0;  // drop any pulse left from an aborted count
        end else if (cnt != '0) begin
            cnt         <= cnt - 1'b1;
            settle_done <= (cnt == CNT_W'(1));  // last step of the count
        end else begin
            settle_done <= 1'b0;  // idle while the dac is off or on
        end
    end

endmodule

// ==== hw/idac_top.sv ====
`timescale 1ns/100ps

module idac_top #(
    parameter int SETTLE_CYCLES = 16  // clock cycles of bias settling
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pdb,
    input  logic [idac_pkg::N_BIN-1:0]    datain,
    input  logic [idac_pkg::N_BIN-1:0]    datainb,
    input  logic [idac_pkg::N_THERM-1:0]  datatherm,
    input  logic [idac_pkg::N_THERM-1:0]  datathermb,
    input  logic [idac_pkg::CAL_W-1:0]    dataical,
    output logic [idac_pkg::SUM_W-1:0]    iout,
    output logic [idac_pkg::SUM_W-1:0]    ioutb,
    output logic [idac_pkg::SUM_W-1:0]    ical,
    output logic                          out_en,
    output logic                          ical_en
);
    import idac_pkg::*;

    logic                       timer_start;
    logic                       settle_done;
    logic                       active;
    logic [N_BIN+N_THERM-1:0]   pos_mask;
    logic [N_BIN+N_THERM-1:0]   neg_mask;
    logic                       cal_bin_red;
    logic [N_BIN+N_THERM-1:0]   cal_therm;

    idac_power_fsm #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_power_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .pdb         (pdb),
        .settle_done (settle_done),
        .timer_start (timer_start),
        .active      (active)
    );

    idac_settle_timer #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_settle_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .settle_done (settle_done)
    );

    idac_cell_decoder u_cell_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .datain      (datain),
        .datainb     (datainb),
        .datatherm   (datatherm),
        .datathermb  (datathermb),
        .dataical    (dataical),
        .pos_mask    (pos_mask),
        .neg_mask    (neg_mask),
        .cal_bin_red (cal_bin_red),
        .cal_therm   (cal_therm)
    );

    idac_current_sum u_current_sum (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .pos_mask    (pos_mask),
        .neg_mask    (neg_mask),
        .cal_bin_red (cal_bin_red),
        .cal_therm   (cal_therm),
        .iout        (iout),
        .ioutb       (ioutb),
        .ical        (ical),
        .out_en      (out_en),
        .ical_en     (ical_en)
    );

endmodule
